/* rtl/display_ctrl_params.svh */
`ifndef DISPLAY_CTRL_PARAMS_SVH
`define DISPLAY_CTRL_PARAMS_SVH

// bus and datapath widths
`define APB_ADDR_W          8
`define DIV_W               6
`define PIXEL_W             24

// pll codes are base minus divider, wrapped to DIV_W bits
`define PLL_CODE_BASE       64

// pll reset pulse length in cycles
`define PLL_RESET_CYCLES    4
// unbroken lock cycles before ready
`define LOCK_SETTLE_CYCLES  16

// divider values out of reset
`define DEF_INPUT_DIV       4
`define DEF_FEEDBACK_DIV    4
`define DEF_OUTPUT_DIV      8

// register byte offsets
`define REG_CLK_DIV         8'h00
`define REG_COMMIT          8'h04
`define REG_STATUS          8'h08
`define REG_PLL_CODES       8'h0C

`endif

/* rtl/display_ctrl_pkg.sv */
`default_nettype none

package display_ctrl_pkg;

    // apb request, driven by the bus master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb response back to the master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // video clock divider settings as software writes them
    typedef struct packed {
        logic [5:0] input_div;
        logic [5:0] feedback_div;
        logic [5:0] output_div;
        logic       use_half;
    } clk_div_cfg_t;

    // select codes for the pll divider pins
    typedef struct packed {
        logic [5:0] idsel;
        logic [5:0] fbdsel;
        logic [5:0] odsel;
    } pll_codes_t;

    // one-hot clock mux select
    typedef enum logic [3:0] {
        CLK_SEL_FULL = 4'b0001,
        CLK_SEL_HALF = 4'b0010
    } clock_sel_e;

    // pll bring-up sequence
    typedef enum logic [1:0] {
        PLL_IN_RESET,
        PLL_WAIT_LOCK,
        PLL_READY
    } pll_state_e;

    // one pixel clock worth of video
    typedef struct packed {
        logic [23:0] pixel;
        logic        hsync;
        logic        vsync;
        logic        de;
    } video_t;

    // register map, byte offsets
    typedef enum logic [7:0] {
        ADDR_CLK_DIV   = 8'h00,
        ADDR_COMMIT    = 8'h04,
        ADDR_STATUS    = 8'h08,
        ADDR_PLL_CODES = 8'h0C
    } reg_addr_e;

endpackage

`default_nettype wire

/* rtl/apb_config_regs.sv */
`default_nettype none
`include "display_ctrl_params.svh"

module apb_config_regs (
    input  wire logic                           clock,
    input  wire logic                           reset_n,
    input  wire display_ctrl_pkg::apb_req_t     apb_req,
    output display_ctrl_pkg::apb_rsp_t          apb_rsp,
    input  wire logic                           pll_ready,
    input  wire logic                           panel_swapped,
    input  wire display_ctrl_pkg::pll_codes_t   pll_codes,
    output display_ctrl_pkg::clk_div_cfg_t      div_cfg,
    output logic                                commit
);

    logic [`APB_ADDR_W-1:0] addr;
    logic                   access;
    logic                   wr_en;
    logic                   sel_clk_div;
    logic                   sel_commit;
    logic                   sel_status;
    logic                   sel_codes;
    logic                   addr_hit;
    logic [31:0]            rd_data;

    display_ctrl_pkg::clk_div_cfg_t div_reg;

    // three 6-bit fields at bytes 0, 1 and 2 of a word
    function automatic logic [31:0] pack_fields(
        input logic [`DIV_W-1:0] lo,
        input logic [`DIV_W-1:0] mid,
        input logic [`DIV_W-1:0] hi
    );
        return (32'(hi) << 16) | (32'(mid) << 8) | 32'(lo);
    endfunction

    assign addr = apb_req.paddr;

    // access phase only, pready is tied high
    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;

    // address decode
    always_comb begin
        sel_clk_div = 1'b0;
        sel_commit  = 1'b0;
        sel_status  = 1'b0;
        sel_codes   = 1'b0;
        case (display_ctrl_pkg::reg_addr_e'(addr))
            display_ctrl_pkg::ADDR_CLK_DIV:   sel_clk_div = 1'b1;
            display_ctrl_pkg::ADDR_COMMIT:    sel_commit  = 1'b1;
            display_ctrl_pkg::ADDR_STATUS:    sel_status  = 1'b1;
            display_ctrl_pkg::ADDR_PLL_CODES: sel_codes   = 1'b1;
            default: ;
        endcase
    end

    assign addr_hit = sel_clk_div | sel_commit | sel_status | sel_codes;

    // divider register, reads back as written
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            div_reg.input_div    <= `DIV_W'(`DEF_INPUT_DIV);
            div_reg.feedback_div <= `DIV_W'(`DEF_FEEDBACK_DIV);
            div_reg.output_div   <= `DIV_W'(`DEF_OUTPUT_DIV);
            div_reg.use_half     <= 1'b0;
        end
        else if (wr_en && sel_clk_div) begin
            div_reg.input_div    <= apb_req.pwdata[`DIV_W-1:0];
            div_reg.feedback_div <= apb_req.pwdata[8 +: `DIV_W];
            div_reg.output_div   <= apb_req.pwdata[16 +: `DIV_W];
            div_reg.use_half     <= apb_req.pwdata[24];
        end
    end

    // single-cycle pulse, the cycle after the access
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            commit <= 1'b0;
        end
        else begin
            commit <= wr_en & sel_commit & apb_req.pwdata[0];
        end
    end

    // read mux
    // commit reads as zero, unmapped reads as zero
    always_comb begin
        rd_data = '0;
        if (sel_clk_div) begin
            rd_data = pack_fields(div_reg.input_div, div_reg.feedback_div,
                                  div_reg.output_div);
            rd_data[24] = div_reg.use_half;
        end
        if (sel_status) begin
            rd_data[0] = pll_ready;
            rd_data[1] = panel_swapped;
        end
        if (sel_codes) begin
            rd_data = pack_fields(pll_codes.idsel, pll_codes.fbdsel, pll_codes.odsel);
        end
    end

    assign apb_rsp = '{
        prdata:  rd_data,
        pready:  1'b1,
        pslverr: access & ~addr_hit
    };

    assign div_cfg = div_reg;

endmodule

`default_nettype wire

/* rtl/pll_control.sv */
`default_nettype none
`include "display_ctrl_params.svh"

module pll_control (
    input  wire logic                           clock,
    input  wire logic                           reset_n,
    input  wire display_ctrl_pkg::clk_div_cfg_t div_cfg,
    input  wire logic                           commit,
    input  wire logic                           pll_lock,
    output display_ctrl_pkg::pll_codes_t        pll_codes,
    output display_ctrl_pkg::clock_sel_e        clock_select,
    output logic                                pll_reset,
    output logic                                pll_ready
);

    // one counter serves both the reset pulse and lock settle
    localparam int CNT_W = $clog2(`LOCK_SETTLE_CYCLES + `PLL_RESET_CYCLES);
    localparam logic [CNT_W-1:0] RESET_LAST  = CNT_W'(`PLL_RESET_CYCLES - 1);
    localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(`LOCK_SETTLE_CYCLES - 1);

    display_ctrl_pkg::pll_state_e state;
    logic [CNT_W-1:0]             count;

    // base minus divider, wrapped to code width
    function automatic logic [`DIV_W-1:0] encode(input logic [`DIV_W-1:0] div);
        logic [`DIV_W:0] full;
        full = (`DIV_W+1)'(`PLL_CODE_BASE) - {1'b0, div};
        return full[`DIV_W-1:0];
    endfunction

    // codes and mux select latch on commit only
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pll_codes.idsel  <= encode(`DIV_W'(`DEF_INPUT_DIV));
            pll_codes.fbdsel <= encode(`DIV_W'(`DEF_FEEDBACK_DIV));
            pll_codes.odsel  <= encode(`DIV_W'(`DEF_OUTPUT_DIV) >> 1);
            clock_select     <= display_ctrl_pkg::CLK_SEL_FULL;
        end
        else if (commit) begin
            pll_codes.idsel  <= encode(div_cfg.input_div);
            pll_codes.fbdsel <= encode(div_cfg.feedback_div);
            // output divider is halved, odd values round down
            pll_codes.odsel  <= encode(div_cfg.output_div >> 1);
            clock_select     <= div_cfg.use_half ? display_ctrl_pkg::CLK_SEL_HALF
                                                 : display_ctrl_pkg::CLK_SEL_FULL;
        end
    end

    // bring-up sequence
    // a commit restarts from reset, even mid-reset
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= display_ctrl_pkg::PLL_IN_RESET;
            count <= '0;
        end
        else if (commit) begin
            state <= display_ctrl_pkg::PLL_IN_RESET;
            count <= '0;
        end
        else begin
            case (state)
                display_ctrl_pkg::PLL_IN_RESET: begin
                    if (count == RESET_LAST) begin
                        state <= display_ctrl_pkg::PLL_WAIT_LOCK;
                        count <= '0;
                    end
                    else begin
                        count <= count + CNT_W'(1);
                    end
                end
                display_ctrl_pkg::PLL_WAIT_LOCK: begin
                    // any lock drop restarts the settle count
                    if (!pll_lock) begin
                        count <= '0;
                    end
                    else if (count == SETTLE_LAST) begin
                        state <= display_ctrl_pkg::PLL_READY;
                        count <= '0;
                    end
                    else begin
                        count <= count + CNT_W'(1);
                    end
                end
                display_ctrl_pkg::PLL_READY: begin
                    if (!pll_lock) begin
                        state <= display_ctrl_pkg::PLL_WAIT_LOCK;
                    end
                end
                default: begin
                    state <= display_ctrl_pkg::PLL_IN_RESET;
                    count <= '0;
                end
            endcase
        end
    end

    assign pll_reset = (state == display_ctrl_pkg::PLL_IN_RESET);
    assign pll_ready = (state == display_ctrl_pkg::PLL_READY);

endmodule

`default_nettype wire

/* rtl/video_output_stage.sv */
`default_nettype none
`include "display_ctrl_params.svh"

module video_output_stage (
    input  wire logic                       clock,
    input  wire logic                       reset_n,
    input  wire logic                       panel_detect_n,
    input  wire display_ctrl_pkg::video_t   video_in,
    output display_ctrl_pkg::video_t        video_out,
    output logic                            panel_swapped
);

    logic                captured;
    logic [`PIXEL_W-1:0] pixel_q;
    logic                hsync_q;
    logic                vsync_q;
    logic                de_q;

    // alternate panel wiring of the upper pixel bits
    // lower 14 bits are the same on both panels
    function automatic logic [`PIXEL_W-1:0] swap_pixel(input logic [`PIXEL_W-1:0] pix);
        logic [`PIXEL_W-1:0] res;
        res     = pix;
        res[18] = pix[14];
        res[23] = pix[15];
        res[17] = pix[16];
        res[22] = pix[17];
        res[16] = pix[18];
        res[21] = pix[19];
        res[15] = pix[20];
        res[20] = pix[21];
        res[14] = pix[22];
        res[19] = pix[23];
        return res;
    endfunction

    // strap sampled once, first cycle out of reset
    // strap pin is active low
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            captured      <= 1'b0;
            panel_swapped <= 1'b0;
        end
        else if (!captured) begin
            captured      <= 1'b1;
            panel_swapped <= ~panel_detect_n;
        end
    end

    // pixel payload, one cycle latency
    always_ff @(posedge clock) begin
        pixel_q <= panel_swapped ? swap_pixel(video_in.pixel) : video_in.pixel;
    end

    // syncs trade places on the alternate panel
    // de passes straight
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            de_q    <= 1'b0;
        end
        else begin
            hsync_q <= panel_swapped ? video_in.vsync : video_in.hsync;
            vsync_q <= panel_swapped ? video_in.hsync : video_in.vsync;
            de_q    <= video_in.de;
        end
    end

    assign video_out = '{
        pixel: pixel_q,
        hsync: hsync_q,
        vsync: vsync_q,
        de:    de_q
    };

endmodule

`default_nettype wire

/* rtl/display_ctrl_top.sv */
`default_nettype none
`include "display_ctrl_params.svh"

module display_ctrl_top (
    input  wire logic                           clock,
    input  wire logic                           reset_n,

    // register bus
    input  wire display_ctrl_pkg::apb_req_t     apb_req,
    output display_ctrl_pkg::apb_rsp_t          apb_rsp,

    // video pll control
    input  wire logic                           pll_lock,
    output logic                                pll_reset,
    output display_ctrl_pkg::pll_codes_t        pll_codes,
    output display_ctrl_pkg::clock_sel_e        clock_select,

    // panel strap and video path
    input  wire logic                           panel_detect_n,
    input  wire display_ctrl_pkg::video_t       video_in,
    output display_ctrl_pkg::video_t            video_out
);

    // config to pll sequencer
    display_ctrl_pkg::clk_div_cfg_t div_cfg;
    logic                           commit;

    // status back to the register block
    logic                           pll_ready;
    logic                           panel_swapped;

    apb_config_regs u_regs (
        .clock         (clock),
        .reset_n       (reset_n),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .pll_ready     (pll_ready),
        .panel_swapped (panel_swapped),
        .pll_codes     (pll_codes),
        .div_cfg       (div_cfg),
        .commit        (commit)
    );

    // codes leave the chip and loop back for read-back
    pll_control u_pll (
        .clock        (clock),
        .reset_n      (reset_n),
        .div_cfg      (div_cfg),
        .commit       (commit),
        .pll_lock     (pll_lock),
        .pll_codes    (pll_codes),
        .clock_select (clock_select),
        .pll_reset    (pll_reset),
        .pll_ready    (pll_ready)
    );

    video_output_stage u_video (
        .clock          (clock),
        .reset_n        (reset_n),
        .panel_detect_n (panel_detect_n),
        .video_in       (video_in),
        .video_out      (video_out),
        .panel_swapped  (panel_swapped)
    );

endmodule

`default_nettype wire

/* sim/display_ctrl_tb.sv */
`default_nettype none
`include "display_ctrl_params.svh"

module display_ctrl_tb;

    // output bit on the alternate panel for each of input bits 14 to 23
    localparam int PIN_MAP [10] = '{18, 23, 17, 22, 16, 21, 15, 20, 14, 19};
    localparam int TIMEOUT_MARGIN = 100;

    logic                         clock;
    logic                         reset_n;
    display_ctrl_pkg::apb_req_t   apb_req;
    display_ctrl_pkg::apb_rsp_t   apb_rsp;
    logic                         pll_lock;
    logic                         pll_reset;
    display_ctrl_pkg::pll_codes_t pll_codes;
    display_ctrl_pkg::clock_sel_e clock_select;
    logic                         panel_detect_n;
    display_ctrl_pkg::video_t     video_in;
    display_ctrl_pkg::video_t     video_out;

    // run control and case parsing
    int          cycle_count = 0;
    int          cycle_limit = TIMEOUT_MARGIN;
    int          fd;
    string       line;
    logic [7:0]  op;
    logic [31:0] a0, a1, a2, a3;
    logic [31:0] rd_data;
    logic        rd_err;
    logic        expect_swap;
    logic [31:0] lfsr = 32'h6a69;

    display_ctrl_top UUT (
        .clock          (clock),
        .reset_n        (reset_n),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .pll_lock       (pll_lock),
        .pll_reset      (pll_reset),
        .pll_codes      (pll_codes),
        .clock_select   (clock_select),
        .panel_detect_n (panel_detect_n),
        .video_in       (video_in),
        .video_out      (video_out)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    // watchdog whose limit grows with every case read
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_on_error($sformatf("timeout, cases not done after %0d cycles", cycle_limit));
        end
    end

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // panel wiring as seen on the output pins
    function automatic display_ctrl_pkg::video_t expected_video(
        input display_ctrl_pkg::video_t v,
        input logic                     swap
    );
        display_ctrl_pkg::video_t r;
        r = v;
        if (swap) begin
            for (int i = 0; i < 10; i++) begin
                r.pixel[PIN_MAP[i]] = v.pixel[14 + i];
            end
            r.hsync = v.vsync;
            r.vsync = v.hsync;
        end
        return r;
    endfunction

    // rough cycle cost of one case
    function automatic int op_cycles(input logic [7:0] kind, input int n, input int m);
        case (kind)
            "W", "R": return 3;
            "N":      return n;
            "X":      return 9;
            "V":      return n + 1;
            "S":      return n + m + 16;
            "K":      return n + 10;
            default:  return 1;
        endcase
    endfunction

    // setup then access then idle
    // a write lands on the last edge
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clock);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clock);
        apb_req.penable <= 1'b1;
        @(negedge clock);
        assert (apb_rsp.pready) else stop_on_error("pready was low in an access cycle");
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clock);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apply_reset(input logic panel_n);
        @(posedge clock);
        reset_n        <= 1'b0;
        panel_detect_n <= panel_n;
        repeat (8) @(posedge clock);
        reset_n <= 1'b1;
        expect_swap = ~panel_n;
    endtask

    // next edge is the first settle count edge
    // ready must be low one cycle before the count ends and high just after
    task automatic check_ready_timing(input int settle);
        logic [31:0] data;
        logic        err;
        repeat (settle - 3) @(posedge clock);
        apb_access(1'b0, `REG_STATUS, '0, data, err);
        assert (data[0] == 1'b0)
            else stop_on_error($sformatf("ERROR: pll_ready got 0x%h expected 0x0", data[0]));
        apb_access(1'b0, `REG_STATUS, '0, data, err);
        assert (data[0] == 1'b1)
            else stop_on_error($sformatf("ERROR: pll_ready got 0x%h expected 0x1", data[0]));
    endtask

    // reset pulse length, then optionally the settle time
    // pll_reset is already high out of reset, else it rises the cycle after commit
    task automatic check_pll_sequence(input int rst_len, input int settle);
        int wait_cnt;
        int high_cnt;
        wait_cnt = 0;
        high_cnt = 0;
        @(negedge clock);
        while (!pll_reset) begin
            wait_cnt++;
            assert (wait_cnt < 2)
                else stop_on_error("pll_reset did not rise in the cycle after the commit pulse");
            @(negedge clock);
        end
        while (pll_reset) begin
            high_cnt++;
            @(negedge clock);
        end
        assert (high_cnt == rst_len)
            else stop_on_error($sformatf("ERROR: pll_reset cycles got 0x%h expected 0x%h",
                                         high_cnt, rst_len));
        if (settle > 0) begin
            check_ready_timing(settle);
        end
    endtask

    task automatic check_pll_outputs(input logic [31:0] id, input logic [31:0] fb,
                                     input logic [31:0] od, input logic [31:0] sel);
        display_ctrl_pkg::pll_codes_t exp_codes;
        exp_codes = '{idsel: id[5:0], fbdsel: fb[5:0], odsel: od[5:0]};
        @(negedge clock);
        assert (pll_codes == exp_codes)
            else stop_on_error($sformatf("ERROR: pll_codes got 0x%h expected 0x%h",
                                         pll_codes, exp_codes));
        assert (clock_select == sel[3:0])
            else stop_on_error($sformatf("ERROR: clock_select got 0x%h expected 0x%h",
                                         clock_select, sel[3:0]));
    endtask

    // random words in with each checked one cycle later
    task automatic video_burst(input int words);
        display_ctrl_pkg::video_t exp_q[$];
        display_ctrl_pkg::video_t word;
        display_ctrl_pkg::video_t expected;
        for (int i = 0; i <= words; i++) begin
            @(posedge clock);
            if (i < words) begin
                for (int b = 0; b < $bits(word); b++) begin
                    word[b] = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                end
                video_in <= word;
                exp_q.push_back(expected_video(word, expect_swap));
            end
            @(negedge clock);
            if (i > 0) begin
                expected = exp_q.pop_front();
                assert (video_out == expected)
                    else stop_on_error($sformatf("ERROR: video_out got 0x%h expected 0x%h",
                                                 video_out, expected));
            end
        end
    endtask

    initial begin
        reset_n        = 1'b0;
        pll_lock       = 1'b0;
        panel_detect_n = 1'b1;
        apb_req        = '0;
        video_in       = '0;
        expect_swap    = 1'b0;
        repeat (8) @(posedge clock);
        reset_n <= 1'b1;

        fd = $fopen("sim/display_ctrl_cases.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the cases file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            a0 = '0;
            a1 = '0;
            a2 = '0;
            a3 = '0;
            void'($sscanf(line, "%c %h %h %h %h", op, a0, a1, a2, a3));
            cycle_limit = cycle_limit + op_cycles(op, a0, a1);
            case (op)
                "W": apb_access(1'b1, a0[7:0], a1, rd_data, rd_err);
                "R": begin
                    apb_access(1'b0, a0[7:0], '0, rd_data, rd_err);
                    assert (rd_data == a1)
                        else stop_on_error($sformatf(
                            "ERROR: prdata at 0x%h got 0x%h expected 0x%h",
                            a0[7:0], rd_data, a1));
                    assert (rd_err == a2[0])
                        else stop_on_error($sformatf(
                            "ERROR: pslverr at 0x%h got 0x%h expected 0x%h",
                            a0[7:0], rd_err, a2[0]));
                end
                "L": begin
                    @(posedge clock);
                    pll_lock <= a0[0];
                end
                "D": begin
                    @(posedge clock);
                    panel_detect_n <= a0[0];
                end
                "N": repeat (a0) @(posedge clock);
                "X": apply_reset(a0[0]);
                "V": video_burst(a0);
                "S": check_pll_sequence(a0, a1);
                // one cycle of lost lock
                "K": begin
                    @(posedge clock);
                    pll_lock <= 1'b0;
                    @(posedge clock);
                    pll_lock <= 1'b1;
                    check_ready_timing(a0);
                end
                "P": check_pll_outputs(a0, a1, a2, a3);
                default: stop_on_error($sformatf("unknown operation %c in the cases file", op));
            endcase
        end
        $fclose(fd);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/display_ctrl_cases.txt */
# one operation per line, values in hex: W addr data | R addr data pslverr | L lock
# D panel_n | N cycles | X panel_n | V words | S reset_len settle | K settle | P id fb od sel
S 4 0
P 3c 3c 3c 1
R 00 00080404 0
R 0c 003c3c3c 0
R 08 0 0
W 00 01051203
R 00 01051203 0
R 04 0 0
R 40 0 1
W 40 ffffffff
R 00 01051203 0
L 1
W 04 1
S 4 10
P 3d 2e 3e 2
R 0c 003e2e3d 0
R 08 1 0
K 10
W 00 003f0100
W 04 1
S 4 10
P 00 3f 21 1
R 0c 00213f00 0
V 20
L 0
X 0
R 08 2 0
V 20
D 1
N 4
R 08 2 0
V 10
X 1
R 08 0 0
V 8

/* vlog.f */
+incdir+rtl
rtl/display_ctrl_pkg.sv
rtl/apb_config_regs.sv
rtl/pll_control.sv
rtl/video_output_stage.sv
rtl/display_ctrl_top.sv
sim/display_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert -f vlog.f --top-module display_ctrl_tb \
    -Mdir obj_dir -o display_ctrl_sim > build.log 2>&1 \
    && ./obj_dir/display_ctrl_sim > sim.log 2>&1 \
    && grep -qx "sim passed" sim.log \
    && echo "run ok, see sim.log" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }
